// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - logic

sources:
  - logic/mipsPkg.sv
  - logic/pipeReg.sv
  - logic/instrFetch.sv
  - logic/controlUnit.sv
  - logic/registerFile.sv
  - logic/executeStage.sv
  - logic/memoryStage.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - tests/mipsCoreTb.sv

// File: filelist.f
+incdir+logic
logic/mipsPkg.sv
logic/pipeReg.sv
logic/instrFetch.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
tests/mipsCoreTb.sv

// File: logic/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  mipsPkg::ifIdT fetch,
  output mipsPkg::ctrlT ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = fetch.instr[31:26];
  assign funct  = fetch.instr[5:0];

  always_comb begin
    ctrl = '0;
    if (fetch.valid) begin
      case (opcode)
        mipsPkg::opRtype: begin
          ctrl.regWrite = 1'b1;
          ctrl.regDst   = 1'b1;
          case (funct)
            mipsPkg::functAdd: ctrl.aluOp = mipsPkg::aluAdd;
            mipsPkg::functSub: ctrl.aluOp = mipsPkg::aluSub;
            mipsPkg::functAnd: ctrl.aluOp = mipsPkg::aluAnd;
            mipsPkg::functOr:  ctrl.aluOp = mipsPkg::aluOr;
            mipsPkg::functSlt: ctrl.aluOp = mipsPkg::aluSlt;
            // unknown funct behaves as a no-op
            default:           ctrl = '0;
          endcase
        end
        mipsPkg::opAddi: begin
          ctrl.regWrite = 1'b1;
          ctrl.aluSrc   = 1'b1;
          ctrl.aluOp    = mipsPkg::aluAdd;
        end
        mipsPkg::opLw: begin
          ctrl.regWrite = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.memRead  = 1'b1;
          ctrl.aluSrc   = 1'b1;
          ctrl.aluOp    = mipsPkg::aluAdd;
        end
        mipsPkg::opSw: begin
          ctrl.memWrite = 1'b1;
          ctrl.aluSrc   = 1'b1;
          ctrl.aluOp    = mipsPkg::aluAdd;
        end
        // compare by subtraction, zero flag decides
        mipsPkg::opBeq: begin
          ctrl.branch = 1'b1;
          ctrl.aluOp  = mipsPkg::aluSub;
        end
        default: ctrl = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// instruction address width, 64 words of instruction memory
`define ADDR_WIDTH 6

// machine word
`define DATA_WIDTH 32

// register index, 32 registers
`define REG_ADDR_WIDTH 5

`endif

// File: logic/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module executeStage (
  input  mipsPkg::idExT  ex,
  output mipsPkg::exMemT mem
);

  logic [`DATA_WIDTH-1:0] operandB;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic [`DATA_WIDTH-1:0] targetSum;

  // immediate for addi, lw and sw
  assign operandB = ex.ctrl.aluSrc ? ex.signImm : ex.regB;

  always_comb begin
    case (ex.ctrl.aluOp)
      mipsPkg::aluAdd: aluResult = ex.srcA + operandB;
      mipsPkg::aluSub: aluResult = ex.srcA - operandB;
      mipsPkg::aluAnd: aluResult = ex.srcA & operandB;
      mipsPkg::aluOr:  aluResult = ex.srcA | operandB;
      mipsPkg::aluSlt: begin
        aluResult = '0;
        aluResult[0] = $signed(ex.srcA) < $signed(operandB);
      end
      default: aluResult = '0;
    endcase
  end

  // word addressed target, offset counts from pc+1
  assign targetSum = ex.signImm + {{(`DATA_WIDTH-`ADDR_WIDTH){1'b0}}, ex.pcPlus1};

  assign mem.valid        = ex.valid;
  assign mem.ctrl         = ex.ctrl;
  assign mem.aluResult    = aluResult;
  assign mem.zero         = (aluResult == '0);
  assign mem.writeData    = ex.regB;
  assign mem.writeReg     = ex.ctrl.regDst ? ex.rd : ex.rt;
  assign mem.branchTarget = targetSum[`ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// File: logic/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module instrFetch (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   loadEn,
  input  logic [`ADDR_WIDTH-1:0] loadAddr,
  input  logic [`DATA_WIDTH-1:0] loadData,
  input  logic                   branchTaken,
  input  logic [`ADDR_WIDTH-1:0] branchTarget,
  output mipsPkg::ifIdT          fetch
);

  logic [`DATA_WIDTH-1:0] imem [2**`ADDR_WIDTH];
  logic [`ADDR_WIDTH-1:0] pc;
  logic [`ADDR_WIDTH-1:0] pcPlus1;

  assign pcPlus1 = pc + `ADDR_WIDTH'(1);

  // branch wins over sequential fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else begin
      pc <= pcPlus1;
    end
  end

  // load port writes while reset holds the pipeline
  always_ff @(posedge clk) begin
    if (loadEn) begin
      imem[loadAddr] <= loadData;
    end
  end

  // no live slot while reset is held
  assign fetch.valid   = !reset;
  assign fetch.instr   = imem[pc];
  assign fetch.pcPlus1 = pcPlus1;

endmodule

`default_nettype wire

// File: logic/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module memoryStage (
  input  mipsPkg::exMemT         mem,
  output logic                   memRead,
  output logic                   memWrite,
  output logic [`DATA_WIDTH-1:0] memAddr,
  output logic [`DATA_WIDTH-1:0] memWriteData,
  output logic                   branchTaken,
  output logic [`ADDR_WIDTH-1:0] branchTarget,
  output mipsPkg::memWbT         wb
);

  // strobes only for live slots
  assign memRead      = mem.valid && mem.ctrl.memRead;
  assign memWrite     = mem.valid && mem.ctrl.memWrite;
  assign memAddr      = mem.aluResult;
  assign memWriteData = mem.writeData;

  // beq resolves here and squashes the three younger slots
  assign branchTaken  = mem.valid && mem.ctrl.branch && mem.zero;
  assign branchTarget = mem.branchTarget;

  // load data arrives next cycle, picked up in writeback
  assign wb.valid     = mem.valid;
  assign wb.regWrite  = mem.ctrl.regWrite;
  assign wb.memToReg  = mem.ctrl.memToReg;
  assign wb.aluResult = mem.aluResult;
  assign wb.writeReg  = mem.writeReg;

endmodule

`default_nettype wire

// File: logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module mipsCore (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   loadEn,
  input  logic [`ADDR_WIDTH-1:0] loadAddr,
  input  logic [`DATA_WIDTH-1:0] loadData,
  input  logic [`DATA_WIDTH-1:0] memReadData,
  output logic                   memRead,
  output logic                   memWrite,
  output logic [`DATA_WIDTH-1:0] memAddr,
  output logic [`DATA_WIDTH-1:0] memWriteData
);

  mipsPkg::ifIdT          ifIdD;
  mipsPkg::ifIdT          ifIdQ;
  mipsPkg::idExT          idExD;
  mipsPkg::idExT          idExQ;
  mipsPkg::exMemT         exMemD;
  mipsPkg::exMemT         exMemQ;
  mipsPkg::memWbT         memWbD;
  mipsPkg::memWbT         memWbQ;
  mipsPkg::ctrlT          ctrlD;
  logic [`DATA_WIDTH-1:0] srcAD;
  logic [`DATA_WIDTH-1:0] regBD;
  logic                   branchTaken;
  logic [`ADDR_WIDTH-1:0] branchTarget;

  instrFetch instrFetch_inst (
    .clk          (clk),
    .reset        (reset),
    .loadEn       (loadEn),
    .loadAddr     (loadAddr),
    .loadData     (loadData),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .fetch        (ifIdD)
  );

  pipeReg #(.payloadT(mipsPkg::ifIdT)) ifIdReg (
    .clk   (clk),
    .reset (reset),
    .flush (branchTaken),
    .d     (ifIdD),
    .q     (ifIdQ)
  );

  // decode, control and register read side by side
  controlUnit controlUnit_inst (
    .fetch (ifIdQ),
    .ctrl  (ctrlD)
  );

  registerFile registerFile_inst (
    .clk         (clk),
    .reset       (reset),
    .fetch       (ifIdQ),
    .wb          (memWbQ),
    .memReadData (memReadData),
    .srcA        (srcAD),
    .regB        (regBD)
  );

  assign idExD = '{
    valid:   ifIdQ.valid,
    ctrl:    ctrlD,
    srcA:    srcAD,
    regB:    regBD,
    rt:      ifIdQ.instr[20:16],
    rd:      ifIdQ.instr[15:11],
    signImm: {{(`DATA_WIDTH-16){ifIdQ.instr[15]}}, ifIdQ.instr[15:0]},
    pcPlus1: ifIdQ.pcPlus1
  };

  pipeReg #(.payloadT(mipsPkg::idExT)) idExReg (
    .clk   (clk),
    .reset (reset),
    .flush (branchTaken),
    .d     (idExD),
    .q     (idExQ)
  );

  executeStage executeStage_inst (
    .ex  (idExQ),
    .mem (exMemD)
  );

  pipeReg #(.payloadT(mipsPkg::exMemT)) exMemReg (
    .clk   (clk),
    .reset (reset),
    .flush (branchTaken),
    .d     (exMemD),
    .q     (exMemQ)
  );

  memoryStage memoryStage_inst (
    .mem          (exMemQ),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .wb           (memWbD)
  );

  // the branch itself moves on, so writeback is never flushed
  pipeReg #(.payloadT(mipsPkg::memWbT)) memWbReg (
    .clk   (clk),
    .reset (reset),
    .flush (1'b0),
    .d     (memWbD),
    .q     (memWbQ)
  );

endmodule

`default_nettype wire

// File: logic/mipsPkg.sv
`default_nettype none

`include "core_params.svh"

package mipsPkg;

  // alu operations
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpT;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    opRtype = 6'd0,
    opBeq   = 6'd4,
    opAddi  = 6'd8,
    opLw    = 6'd35,
    opSw    = 6'd43
  } opcodeT;

  // r-type funct codes, instr[5:0]
  localparam logic [5:0] functAdd = 6'd32;
  localparam logic [5:0] functSub = 6'd34;
  localparam logic [5:0] functAnd = 6'd36;
  localparam logic [5:0] functOr  = 6'd37;
  localparam logic [5:0] functSlt = 6'd42;

  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    // second operand is the immediate
    logic  aluSrc;
    // destination is rd, not rt
    logic  regDst;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    logic                   valid;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`ADDR_WIDTH-1:0] pcPlus1;
  } ifIdT;

  typedef struct packed {
    logic                       valid;
    ctrlT                       ctrl;
    logic [`DATA_WIDTH-1:0]     srcA;
    logic [`DATA_WIDTH-1:0]     regB;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]     signImm;
    logic [`ADDR_WIDTH-1:0]     pcPlus1;
  } idExT;

  typedef struct packed {
    logic                       valid;
    ctrlT                       ctrl;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic                       zero;
    logic [`DATA_WIDTH-1:0]     writeData;
    logic [`REG_ADDR_WIDTH-1:0] writeReg;
    logic [`ADDR_WIDTH-1:0]     branchTarget;
  } exMemT;

  typedef struct packed {
    logic                       valid;
    logic                       regWrite;
    logic                       memToReg;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic [`REG_ADDR_WIDTH-1:0] writeReg;
  } memWbT;

endpackage

`default_nettype wire

// File: logic/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

// generic stage register between two pipeline stages
module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // an all-zero payload is a bubble, valid is clear
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: logic/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module registerFile (
  input  logic                   clk,
  input  logic                   reset,
  input  mipsPkg::ifIdT          fetch,
  input  mipsPkg::memWbT         wb,
  input  logic [`DATA_WIDTH-1:0] memReadData,
  output logic [`DATA_WIDTH-1:0] srcA,
  output logic [`DATA_WIDTH-1:0] regB
);

  logic [`DATA_WIDTH-1:0]     regs [2**`REG_ADDR_WIDTH];
  logic [`REG_ADDR_WIDTH-1:0] rs;
  logic [`REG_ADDR_WIDTH-1:0] rt;
  logic [`DATA_WIDTH-1:0]     wbValue;
  logic                       writeEn;

  assign rs = fetch.instr[25:21];
  assign rt = fetch.instr[20:16];

  // writeback result select
  assign wbValue = wb.memToReg ? memReadData : wb.aluResult;
  assign writeEn = wb.valid && wb.regWrite && (wb.writeReg != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[wb.writeReg] <= wbValue;
    end
  end

  // r0 is hardwired, then same-cycle write bypass
  assign srcA = (rs == '0) ? '0 :
                (writeEn && rs == wb.writeReg) ? wbValue : regs[rs];
  assign regB = (rt == '0) ? '0 :
                (writeEn && rt == wb.writeReg) ? wbValue : regs[rt];

endmodule

`default_nettype wire

// File: tests/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module mipsCoreTb;

  localparam int ResetCycles = 3;
  localparam int ImemWords   = 2**`ADDR_WIDTH;

  logic                   clk;
  logic                   reset;
  logic                   loadEn;
  logic [`ADDR_WIDTH-1:0] loadAddr;
  logic [`DATA_WIDTH-1:0] loadData;
  logic [`DATA_WIDTH-1:0] memReadData;
  logic                   memRead;
  logic                   memWrite;
  logic [`DATA_WIDTH-1:0] memAddr;
  logic [`DATA_WIDTH-1:0] memWriteData;

  // per-case ranges index the flat program and store queues
  string                  caseName [$];
  int                     caseBudget [$];
  int                     progFirst [$];
  int                     progLast [$];
  int                     expFirst [$];
  int                     expLast [$];
  logic [`DATA_WIDTH-1:0] progAddr [$];
  logic [`DATA_WIDTH-1:0] progWord [$];
  logic [`DATA_WIDTH-1:0] expAddr [$];
  logic [`DATA_WIDTH-1:0] expData [$];

  // data memory model
  logic [`DATA_WIDTH-1:0] dmem [bit [`DATA_WIDTH-1:0]];

  int errorCount;
  int passCount;
  int failCount;
  int watchdogCycles;

  mipsCore mipsCore_inst (
    .clk          (clk),
    .reset        (reset),
    .loadEn       (loadEn),
    .loadAddr     (loadAddr),
    .loadData     (loadData),
    .memReadData  (memReadData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData)
  );

  always #5 clk = ~clk;

  // untouched locations read as zero
  function automatic logic [`DATA_WIDTH-1:0] readMemory(input logic [`DATA_WIDTH-1:0] addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end
    return '0;
  endfunction

  task automatic readCases();
    int                     fd;
    int                     code;
    int                     budget;
    string                  line;
    string                  tag;
    string                  name;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] w;
    fd = $fopen("tests/programCases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file tests/programCases.txt");
      errorCount++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0) begin
        code = $sscanf(line, "%s", tag);
      end
      if (code > 0 && tag[0] != "#") begin
        if (tag == "C") begin
          code = $sscanf(line, "%s %s %d", tag, name, budget);
          caseName.push_back(name);
          caseBudget.push_back(budget);
          progFirst.push_back(progAddr.size());
          expFirst.push_back(expAddr.size());
        end else if (tag == "P") begin
          code = $sscanf(line, "%s %h %h", tag, a, w);
          progAddr.push_back(a);
          progWord.push_back(w);
        end else if (tag == "E") begin
          code = $sscanf(line, "%s %h %h", tag, a, w);
          expAddr.push_back(a);
          expData.push_back(w);
        end else if (tag == "R") begin
          progLast.push_back(progAddr.size());
          expLast.push_back(expAddr.size());
        end else begin
          $display("cases file has a line with an unknown tag: %s", tag);
          errorCount++;
        end
      end
    end
    $fclose(fd);
  endtask

  // unlisted words load as zero, which decodes as a no-op
  task automatic loadProgram(input int c);
    logic [`DATA_WIDTH-1:0] image [ImemWords];
    for (int i = 0; i < ImemWords; i++) begin
      image[i] = '0;
    end
    for (int p = progFirst[c]; p < progLast[c]; p++) begin
      image[progAddr[p][`ADDR_WIDTH-1:0]] = progWord[p];
    end
    reset = 1'b1;
    repeat (ResetCycles) @(negedge clk);
    for (int i = 0; i < ImemWords; i++) begin
      loadEn   = 1'b1;
      loadAddr = `ADDR_WIDTH'(i);
      loadData = image[i];
      @(negedge clk);
    end
    loadEn = 1'b0;
    reset  = 1'b0;
  endtask

  task automatic runCase(input int c);
    int                     cycles;
    int                     seen;
    int                     total;
    int                     idx;
    int                     caseErrors;
    logic                   readPending;
    logic [`DATA_WIDTH-1:0] readAddr;
    cycles      = 0;
    seen        = 0;
    caseErrors  = 0;
    readPending = 1'b0;
    readAddr    = '0;
    total       = expLast[c] - expFirst[c];
    dmem.delete();
    memReadData = '0;
    loadProgram(c);
    while (seen < total && cycles < caseBudget[c]) begin
      @(negedge clk);
      cycles++;
      // answer the strobe seen on the previous falling edge
      memReadData = readPending ? readMemory(readAddr) : '0;
      readPending = memRead;
      readAddr    = memAddr;
      // a slot is either a load or a store
      assert (!(memRead && memWrite)) else begin
        $display("case %s: read and write strobes are both high in cycle %0d",
                 caseName[c], cycles);
        caseErrors++;
      end
      if (memWrite) begin
        idx = expFirst[c] + seen;
        assert (memAddr === expAddr[idx] && memWriteData === expData[idx]) else begin
          $display("[ERROR] %s: expected [%h] = %h, actual [%h] = %h", caseName[c],
                   expAddr[idx], expData[idx], memAddr, memWriteData);
          caseErrors++;
        end
        dmem[memAddr] = memWriteData;
        seen++;
      end
    end
    assert (seen == total) else begin
      $display("case %s ran out of its %0d cycle budget with %0d of %0d stores seen",
               caseName[c], caseBudget[c], seen, total);
      caseErrors++;
    end
    errorCount += caseErrors;
    if (caseErrors == 0) begin
      passCount++;
      $display("case %s: passed, %0d stores in %0d cycles", caseName[c], seen, cycles);
    end else begin
      failCount++;
      $display("case %s: failed with %0d errors", caseName[c], caseErrors);
    end
  endtask

  initial begin
    int limit;
    clk            = 1'b0;
    reset          = 1'b1;
    loadEn         = 1'b0;
    loadAddr       = '0;
    loadData       = '0;
    memReadData    = '0;
    errorCount     = 0;
    passCount      = 0;
    failCount      = 0;
    watchdogCycles = 0;
    limit          = 0;
    readCases();
    for (int c = 0; c < progLast.size(); c++) begin
      limit += caseBudget[c] + ResetCycles + ImemWords + 4;
    end
    watchdogCycles = limit;
    for (int c = 0; c < progLast.size(); c++) begin
      runCase(c);
    end
    $display("%0d cases run, %0d passed, %0d failed, %0d errors",
             passCount + failCount, passCount, failCount, errorCount);
    if (errorCount == 0 && failCount == 0 && passCount > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // armed once the total length of the cases is known
  initial begin
    wait (watchdogCycles > 0);
    repeat (watchdogCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is hung", watchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/programCases.txt
# C name budget | P addr word (hex, rest of line is a note) | E addr data (hex, in store order)
# R runs the case; unlisted instruction words are zero, which decodes as a no-op
C alu 40
P 00 20010007 addi r1, r0, 7
P 01 2002fffd addi r2, r0, -3
P 04 00221820 add r3, r1, r2
P 05 00222022 sub r4, r1, r2
P 06 00222824 and r5, r1, r2
P 07 00223025 or r6, r1, r2
P 08 0041382a slt r7, r2, r1
P 09 ac030010 sw r3, 0x10(r0)
P 0a ac040014 sw r4, 0x14(r0)
P 0b ac070020 sw r7, 0x20(r0) two slots after slt
P 0c ac050018 sw r5, 0x18(r0)
P 0d ac06001c sw r6, 0x1c(r0)
E 00000010 00000004
E 00000014 0000000a
E 00000020 00000001
E 00000018 00000005
E 0000001c ffffffff
R
C bypass 30
P 00 20010055 addi r1, r0, 0x55
P 01 2002ffff addi r2, r0, -1
P 03 ac0100d0 sw r1, 0xd0(r0)
P 04 ac0200d4 sw r2, 0xd4(r0)
E 000000d0 00000055
E 000000d4 ffffffff
R
C loadstore 40
P 00 20011234 addi r1, r0, 0x1234
P 01 20020080 addi r2, r0, 0x80
P 04 ac410004 sw r1, 4(r2)
P 05 8c430004 lw r3, 4(r2)
P 08 ac030090 sw r3, 0x90(r0)
E 00000084 00001234
E 00000090 00001234
R
C zeroreg 40
P 00 20000077 addi r0, r0, 0x77
P 01 20010005 addi r1, r0, 5
P 03 ac0000a0 sw r0, 0xa0(r0)
P 04 00210020 add r0, r1, r1
P 07 ac0000a4 sw r0, 0xa4(r0)
P 08 00011020 add r2, r0, r1
P 0b ac0200a8 sw r2, 0xa8(r0)
E 000000a0 00000000
E 000000a4 00000000
E 000000a8 00000005
R
C branch 40
P 00 20010003 addi r1, r0, 3
P 01 20020003 addi r2, r0, 3
P 02 20030009 addi r3, r0, 9
P 05 10230008 beq r1, r3, +8 not taken
P 06 ac0100b0 sw r1, 0xb0(r0)
P 07 10220005 beq r1, r2, +5 taken to 0x0d
P 08 ac0300bc sw r3, 0xbc(r0) squashed
P 09 ac0300bc sw r3, 0xbc(r0) squashed
P 0a ac0300bc sw r3, 0xbc(r0) squashed
P 0c ac0100b8 sw r1, 0xb8(r0) skipped by the target
P 0d ac0200b4 sw r2, 0xb4(r0)
E 000000b0 00000003
E 000000b4 00000003
R
C unknown 40
P 00 20010021 addi r1, r0, 0x21
P 01 fc21ffff opcode 63
P 02 0021083f r-type funct 63, rd r1
P 03 a80100c0 opcode 42, next to sw
P 06 ac0100c4 sw r1, 0xc4(r0)
E 000000c4 00000021
R
